//--- project.f
source/lock_pkg.sv
source/tone_pkg.sv
source/key_decoder.sv
source/code_lock.sv
source/tone_generator.sv
source/keypad_lock_top.sv
tests/lock_checker.sv
tests/tb_keypad_lock.sv

//--- tests/tb_keypad_lock.sv
module tb_keypad_lock import lock_pkg::*; import tone_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned HALF_CLICK    = 2;
    localparam int unsigned HALF_SUCCESS  = 1;
    localparam int unsigned HALF_FAIL     = 4;
    localparam int unsigned MAX_STEPS     = 40;
    localparam int unsigned CHECK_TIMEOUT = 1000;  // cycles per step

    typedef struct packed {
        keys_t      key;
        logic [7:0] hold;     // cycles the key stays down
        display_t   disp;
        tries_t     tries;
        logic       tone_on;
        tone_kind_e tone;
    } step_t;

    logic        clk = 1'b0;
    logic        rst_n;
    keys_t       keys;
    display_t    display;
    tries_t      tries;
    logic        buzzer;
    logic        check_req;
    logic [7:0]  step_idx;
    display_t    exp_display;
    tries_t      exp_tries;
    logic [7:0]  exp_half;
    logic        busy;
    logic [15:0] errors;
    logic [15:0] checks;

    step_t       steps [MAX_STEPS];
    int unsigned n_steps;

    always #2 clk = ~clk;

    keypad_lock_top #(
        .PASSCODE     (12'h246),
        .MAX_TRIES    (3),
        .HALF_CLICK   (HALF_CLICK),
        .HALF_SUCCESS (HALF_SUCCESS),
        .HALF_FAIL    (HALF_FAIL),
        .LEN_UNIT     (16)
    ) i_keypad_lock_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .display (display),
        .tries   (tries),
        .buzzer  (buzzer)
    );

    lock_checker i_lock_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .display     (display),
        .tries       (tries),
        .buzzer      (buzzer),
        .check_req   (check_req),
        .step_idx    (step_idx),
        .exp_display (exp_display),
        .exp_tries   (exp_tries),
        .exp_half    (exp_half),
        .busy        (busy),
        .errors      (errors),
        .checks      (checks)
    );

    function automatic int unsigned half_for(input tone_kind_e kind);
        case (kind)
            TONE_SUCCESS: return HALF_SUCCESS;
            TONE_FAIL:    return HALF_FAIL;
            default:      return HALF_CLICK;
        endcase
    endfunction

    task automatic add_step(input keys_t key, input int unsigned hold, input display_t disp,
                            input tries_t tr, input logic tone_on, input tone_kind_e tone);
        steps[n_steps] = '{key: key, hold: 8'(hold), disp: disp, tries: tr,
                           tone_on: tone_on, tone: tone};
        n_steps = n_steps + 1;
    endtask

    task automatic fill_table();
        n_steps = 0;
        add_step(16'h0040, 2, 12'hFF2, 0, 1, TONE_CLICK);    // 2
        add_step(16'h0800, 2, 12'hF24, 0, 1, TONE_CLICK);    // 4
        add_step(16'h0200, 2, 12'h246, 0, 1, TONE_CLICK);    // 6
        add_step(16'h0001, 2, 12'hA55, 0, 1, TONE_SUCCESS);  // enter, opens
        add_step(16'h1000, 2, 12'hFFF, 0, 0, TONE_CLICK);    // clear relocks
        add_step(16'h0080, 2, 12'hFF1, 0, 1, TONE_CLICK);
        add_step(16'h0020, 2, 12'hF13, 0, 1, TONE_CLICK);
        add_step(16'h0400, 2, 12'h135, 0, 1, TONE_CLICK);
        add_step(16'h0001, 2, 12'hFFF, 1, 1, TONE_FAIL);     // wrong code
        add_step(16'h8000, 2, 12'hFF7, 1, 1, TONE_CLICK);
        add_step(16'h4000, 2, 12'hF78, 1, 1, TONE_CLICK);
        add_step(16'h2000, 2, 12'h789, 1, 1, TONE_CLICK);
        add_step(16'h0008, 2, 12'h789, 1, 0, TONE_CLICK);    // fourth digit ignored
        add_step(16'h1000, 2, 12'hFFF, 1, 0, TONE_CLICK);    // clear keeps tries
        add_step(16'h0080, 2, 12'hFF1, 1, 1, TONE_CLICK);
        add_step(16'h0040, 2, 12'hF12, 1, 1, TONE_CLICK);
        add_step(16'h0001, 2, 12'hF12, 1, 0, TONE_CLICK);    // enter on two digits
        add_step(16'h1000, 2, 12'hFFF, 1, 0, TONE_CLICK);
        add_step(16'h0020, 20, 12'hFF3, 1, 1, TONE_CLICK);   // long hold, one digit
        add_step(16'h0440, 2, 12'hFF3, 1, 0, TONE_CLICK);    // two keys at once
        add_step(16'h0002, 2, 12'hFF3, 1, 0, TONE_CLICK);    // unused lines
        add_step(16'h0010, 2, 12'hFF3, 1, 0, TONE_CLICK);
        add_step(16'h0800, 2, 12'hF34, 1, 1, TONE_CLICK);
        add_step(16'h0400, 2, 12'h345, 1, 1, TONE_CLICK);
        add_step(16'h0001, 2, 12'hFFF, 2, 1, TONE_FAIL);
        add_step(16'h2000, 2, 12'hFF9, 2, 1, TONE_CLICK);
        add_step(16'h2000, 3, 12'hF99, 2, 1, TONE_CLICK);
        add_step(16'h2000, 2, 12'h999, 2, 1, TONE_CLICK);
        add_step(16'h0001, 2, 12'h000, 3, 1, TONE_FAIL);     // third failure locks out
        add_step(16'h0040, 2, 12'h000, 3, 0, TONE_CLICK);
        add_step(16'h0001, 2, 12'h000, 3, 0, TONE_CLICK);
        add_step(16'h0100, 2, 12'hFFF, 0, 0, TONE_CLICK);    // master reset
        add_step(16'h0040, 2, 12'hFF2, 0, 1, TONE_CLICK);
    endtask

    task automatic apply_step(input int unsigned idx, output bit timed_out);
        int unsigned gap;
        int unsigned waited;
        step_t       s;
        s   = steps[idx];
        gap = 2 + ($urandom % 4);
        @(posedge clk);
        #1 keys = s.key;
        repeat (s.hold) @(posedge clk);
        #1 keys = '0;
        repeat (gap) @(posedge clk);
        #1;
        step_idx    = 8'(idx);
        exp_display = s.disp;
        exp_tries   = s.tries;
        exp_half    = s.tone_on ? 8'(half_for(s.tone)) : 8'd0;
        check_req   = 1'b1;
        @(posedge clk);
        #1 check_req = 1'b0;
        waited = 0;
        while (busy && waited < CHECK_TIMEOUT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        timed_out = busy;
        if (busy) begin
            $display("Step %0d was not checked within %0d cycles", idx, CHECK_TIMEOUT);
        end
    endtask

    initial begin
        int unsigned i;
        int unsigned seed_val;
        bit          timed_out;
        rst_n       = 1'b0;
        keys        = '0;
        check_req   = 1'b0;
        step_idx    = '0;
        exp_display = DISP_BLANK;
        exp_tries   = '0;
        exp_half    = '0;
        timed_out   = 1'b0;
        seed_val    = $urandom(32'h31c76d4b);  // seeds the release gaps
        fill_table();
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        for (i = 0; i < n_steps && !timed_out; i++) begin
            apply_step(i, timed_out);
        end
        $display("%0d of %0d steps checked, %0d failed", checks, n_steps, errors);
        if (!timed_out && errors == 0 && checks == n_steps) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tests/lock_checker.sv
module lock_checker import lock_pkg::*; #(
    parameter int unsigned QUIET_CYCLES = 40,   // longer than the silent unit of a fail
    parameter int unsigned TIMEOUT      = 300
) (
    input  logic        clk,
    input  logic        rst_n,
    input  display_t    display,
    input  tries_t      tries,
    input  logic        buzzer,
    input  logic        check_req,
    input  logic [7:0]  step_idx,
    input  display_t    exp_display,
    input  tries_t      exp_tries,
    input  logic [7:0]  exp_half,     // 0 when no tone is expected
    output logic        busy,
    output logic [15:0] errors,
    output logic [15:0] checks
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned high_cnt;  // high cycles of the first pulse since re-arm
    int unsigned high_len;  // length of that pulse once it has closed
    int unsigned low_run;   // consecutive low cycles

    // buzzer is sampled on the falling edge, away from the DUT's updates
    task automatic next_cycle();
        @(negedge clk);
        if (buzzer) begin
            low_run = 0;
            if (high_len == 0) begin
                high_cnt = high_cnt + 1;
            end
        end else begin
            low_run = low_run + 1;
            if (high_cnt != 0 && high_len == 0) begin
                high_len = high_cnt;  // first pulse done
            end
        end
    endtask

    task automatic run_check();
        int unsigned waited;
        bit          step_err;
        busy     = 1'b1;
        checks   = checks + 1'b1;
        step_err = 1'b0;
        if (display !== exp_display || tries !== exp_tries) begin
            $display("** Error at %0t: step %0d display %h tries %0d, expected %h tries %0d",
                     $time, step_idx, display, tries, exp_display, exp_tries);
            step_err = 1'b1;
        end
        if (exp_half != 0) begin
            waited = 0;
            while (high_len == 0 && waited < TIMEOUT) begin
                next_cycle();
                waited = waited + 1;
            end
            if (high_len == 0) begin
                $display("Step %0d: the buzzer never sounded within %0d cycles",
                         step_idx, TIMEOUT);
                step_err = 1'b1;
            end else if (high_len != exp_half) begin
                $display("** Error at %0t: step %0d first high phase %0d cycles, expected %0d",
                         $time, step_idx, high_len, exp_half);
                step_err = 1'b1;
            end
        end
        repeat (8) next_cycle();  // room for a stray tone to start
        waited = 0;
        while (low_run < QUIET_CYCLES && waited < TIMEOUT) begin
            next_cycle();
            waited = waited + 1;
        end
        if (low_run < QUIET_CYCLES) begin
            $display("Step %0d: the buzzer did not fall silent within %0d cycles",
                     step_idx, TIMEOUT);
            step_err = 1'b1;
        end else if (exp_half == 0 && high_cnt != 0) begin
            $display("** Error at %0t: step %0d buzzer sounded, no tone expected",
                     $time, step_idx);
            step_err = 1'b1;
        end
        if (step_err) begin
            errors = errors + 1'b1;
        end else begin
            $display("Step %0d passed: display %h tries %0d", step_idx, display, tries);
        end
        high_cnt = 0;  // re-arm for the next press
        high_len = 0;
        busy     = 1'b0;
    endtask

    initial begin
        busy     = 1'b0;
        errors   = '0;
        checks   = '0;
        high_cnt = 0;
        high_len = 0;
        low_run  = 0;
        forever begin
            next_cycle();
            if (rst_n && check_req) begin
                run_check();
            end
        end
    end

endmodule

//--- source/keypad_lock_top.sv
module keypad_lock_top import lock_pkg::*; import tone_pkg::*; #(
    parameter display_t    PASSCODE     = 12'h246,
    parameter int unsigned MAX_TRIES    = 6,
    parameter int unsigned HALF_CLICK   = 50_000,   // 500 Hz at 50 MHz
    parameter int unsigned HALF_SUCCESS = 25_000,
    parameter int unsigned HALF_FAIL    = 100_000,
    parameter int unsigned LEN_UNIT     = 5_000_000  // 100 ms
) (
    input  logic     clk,
    input  logic     rst_n,
    input  keys_t    keys,
    output display_t display,
    output tries_t   tries,
    output logic     buzzer
);

    logic      key_stb;
    key_evt_t  key_evt;
    logic      tone_stb;
    tone_req_t tone_req;

    key_decoder i_key_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .key_stb (key_stb),
        .key_evt (key_evt)
    );

    code_lock #(
        .PASSCODE  (PASSCODE),
        .MAX_TRIES (MAX_TRIES)
    ) i_code_lock (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_stb  (key_stb),
        .key_evt  (key_evt),
        .display  (display),
        .tries    (tries),
        .tone_stb (tone_stb),
        .tone_req (tone_req)
    );

    tone_generator #(
        .HALF_CLICK   (HALF_CLICK),
        .HALF_SUCCESS (HALF_SUCCESS),
        .HALF_FAIL    (HALF_FAIL),
        .LEN_UNIT     (LEN_UNIT)
    ) i_tone_generator (
        .clk      (clk),
        .rst_n    (rst_n),
        .tone_stb (tone_stb),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

endmodule

//--- source/tone_generator.sv
module tone_generator import tone_pkg::*; #(
    parameter int unsigned HALF_CLICK   = 50_000,
    parameter int unsigned HALF_SUCCESS = 25_000,
    parameter int unsigned HALF_FAIL    = 100_000,
    parameter int unsigned LEN_UNIT     = 5_000_000
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tone_stb,
    input  tone_req_t tone_req,
    output logic      buzzer
);

    localparam int unsigned HALF_MAX =
        (HALF_CLICK > HALF_SUCCESS) ?
        ((HALF_CLICK > HALF_FAIL) ? HALF_CLICK : HALF_FAIL) :
        ((HALF_SUCCESS > HALF_FAIL) ? HALF_SUCCESS : HALF_FAIL);
    localparam int HW = $clog2(HALF_MAX + 1);
    localparam int LW = $clog2(LEN_UNIT + 1);

    typedef logic [HW-1:0] half_t;
    typedef logic [LW-1:0] len_t;

    tone_kind_e kind;       // latest request
    logic       active;
    logic       wave;       // square wave before muting
    half_t      ph_cnt;     // cycles into the current half-period
    len_t       cyc_cnt;    // cycles into the current unit
    unit_t      unit_cnt;
    half_t      half;
    unit_t      last_unit;
    logic       mute;

    always_comb begin
        case (kind)
            TONE_SUCCESS: begin
                half      = half_t'(HALF_SUCCESS);
                last_unit = unit_t'(SUCCESS_UNITS - 1);
            end
            TONE_FAIL: begin
                half      = half_t'(HALF_FAIL);
                last_unit = unit_t'(FAIL_UNITS - 1);
            end
            default: begin
                half      = half_t'(HALF_CLICK);
                last_unit = unit_t'(CLICK_UNITS - 1);
            end
        endcase
    end

    assign mute   = (kind == TONE_FAIL) && (unit_cnt == unit_t'(FAIL_MUTE_UNIT));
    assign buzzer = wave && !mute;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            wave     <= 1'b0;
            ph_cnt   <= '0;
            cyc_cnt  <= '0;
            unit_cnt <= '0;
        end else if (tone_stb) begin  // new request pre-empts
            active   <= 1'b1;
            wave     <= 1'b1;
            ph_cnt   <= half_t'(1);
            cyc_cnt  <= len_t'(1);
            unit_cnt <= '0;
        end else if (active) begin
            if (ph_cnt == half) begin
                wave   <= ~wave;
                ph_cnt <= half_t'(1);
            end else begin
                ph_cnt <= ph_cnt + 1'b1;
            end
            if (cyc_cnt == len_t'(LEN_UNIT)) begin
                cyc_cnt <= len_t'(1);
                if (unit_cnt == last_unit) begin  // pattern done, end low
                    active <= 1'b0;
                    wave   <= 1'b0;
                end else begin
                    unit_cnt <= unit_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tone_stb) begin
            kind <= tone_req.kind;
        end
    end

    a_quiet_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !active |-> !buzzer
    );

endmodule

//--- source/code_lock.sv
module code_lock import lock_pkg::*; import tone_pkg::*; #(
    parameter display_t    PASSCODE  = 12'h246,
    parameter int unsigned MAX_TRIES = 6
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_stb,
    input  key_evt_t  key_evt,
    output display_t  display,
    output tries_t    tries,
    output logic      tone_stb,
    output tone_req_t tone_req
);

    lock_state_e state;
    lock_state_e state_nxt;
    digit_cnt_t  digit_cnt;
    digit_cnt_t  cnt_nxt;
    display_t    disp_nxt;
    tries_t      tries_nxt;
    tries_t      tries_inc;
    logic        tone_go;
    tone_kind_e  tone_kind;

    assign tries_inc = tries + 1'b1;

    always_comb begin
        state_nxt = state;
        disp_nxt  = display;
        tries_nxt = tries;
        cnt_nxt   = digit_cnt;
        tone_go   = 1'b0;
        tone_kind = TONE_CLICK;
        if (key_stb) begin
            if (key_evt.kind == KEY_RESET) begin  // master reset, any state
                state_nxt = ST_ENTRY;
                disp_nxt  = DISP_BLANK;
                tries_nxt = '0;
                cnt_nxt   = '0;
            end else begin
                case (state)
                    ST_ENTRY: begin
                        case (key_evt.kind)
                            KEY_DIGIT: begin
                                if (digit_cnt < digit_cnt_t'(NUM_DIGITS)) begin
                                    disp_nxt = {display[7:0], key_evt.digit};  // shift left
                                    cnt_nxt  = digit_cnt + 1'b1;
                                    tone_go  = 1'b1;
                                end
                            end
                            KEY_ENTER: begin
                                if (digit_cnt == digit_cnt_t'(NUM_DIGITS)) begin
                                    cnt_nxt = '0;
                                    tone_go = 1'b1;
                                    if (display == PASSCODE) begin
                                        state_nxt = ST_OPEN;
                                        disp_nxt  = DISP_OPEN;
                                        tone_kind = TONE_SUCCESS;
                                    end else begin
                                        tries_nxt = tries_inc;
                                        tone_kind = TONE_FAIL;
                                        if (tries_inc == tries_t'(MAX_TRIES)) begin
                                            state_nxt = ST_LOCKOUT;
                                            disp_nxt  = DISP_LOCKED;
                                        end else begin
                                            disp_nxt = DISP_BLANK;
                                        end
                                    end
                                end
                            end
                            KEY_CLEAR: begin
                                disp_nxt = DISP_BLANK;  // tries kept
                                cnt_nxt  = '0;
                            end
                            default: ;
                        endcase
                    end
                    ST_OPEN: begin
                        if (key_evt.kind == KEY_CLEAR) begin  // relock
                            state_nxt = ST_ENTRY;
                            disp_nxt  = DISP_BLANK;
                            cnt_nxt   = '0;
                        end
                    end
                    default: ;  // lockout waits for master reset
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_ENTRY;
            display   <= DISP_BLANK;
            tries     <= '0;
            digit_cnt <= '0;
            tone_stb  <= 1'b0;
        end else begin
            state     <= state_nxt;
            display   <= disp_nxt;
            tries     <= tries_nxt;
            digit_cnt <= cnt_nxt;
            tone_stb  <= tone_go;
        end
    end

    always_ff @(posedge clk) begin
        if (tone_go) begin
            tone_req <= '{kind: tone_kind};
        end
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        digit_cnt <= digit_cnt_t'(NUM_DIGITS)
    );

    // lockout must freeze the counter at the limit
    a_tries_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        tries <= tries_t'(MAX_TRIES)
    );

endmodule

//--- source/key_decoder.sv
module key_decoder import lock_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  keys_t    keys,
    output logic     key_stb,
    output key_evt_t key_evt
);

    keys_t    keys_q;     // sampled keypad
    keys_t    keys_prev;  // sample from the cycle before
    logic     mapped;
    logic     press;
    key_evt_t evt_nxt;

    // single-bit values on a mapped line only
    always_comb begin
        mapped  = 1'b1;
        evt_nxt = '{kind: KEY_DIGIT, digit: DIGIT_BLANK};
        case (keys_q)
            16'h0001: evt_nxt.kind  = KEY_ENTER;
            16'h0008: evt_nxt.digit = 4'd0;
            16'h0080: evt_nxt.digit = 4'd1;
            16'h0040: evt_nxt.digit = 4'd2;
            16'h0020: evt_nxt.digit = 4'd3;
            16'h0800: evt_nxt.digit = 4'd4;
            16'h0400: evt_nxt.digit = 4'd5;
            16'h0200: evt_nxt.digit = 4'd6;
            16'h8000: evt_nxt.digit = 4'd7;
            16'h4000: evt_nxt.digit = 4'd8;
            16'h2000: evt_nxt.digit = 4'd9;
            16'h1000: evt_nxt.kind  = KEY_CLEAR;
            16'h0100: evt_nxt.kind  = KEY_RESET;
            default:  mapped = 1'b0;  // idle, multi-key or unused line
        endcase
    end

    assign press = mapped && (keys_prev == '0);  // only right after a release

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keys_q    <= '0;
            keys_prev <= '0;
            key_stb   <= 1'b0;
        end else begin
            keys_q    <= keys;
            keys_prev <= keys_q;
            key_stb   <= press;
        end
    end

    always_ff @(posedge clk) begin
        if (press) begin
            key_evt <= evt_nxt;
        end
    end

    // a press needs an idle sample before it, so strobes never come back to back
    a_stb_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_stb |=> !key_stb
    );

endmodule

//--- source/tone_pkg.sv
package tone_pkg;

    typedef logic [2:0] unit_t;  // tone length in units

    // pattern lengths in units
    localparam int unsigned CLICK_UNITS    = 2;
    localparam int unsigned SUCCESS_UNITS  = 6;
    localparam int unsigned FAIL_UNITS     = 3;
    localparam int unsigned FAIL_MUTE_UNIT = 1;  // silent gap of the fail tone

    typedef enum logic [1:0] {
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_kind_e;

    typedef struct packed {
        tone_kind_e kind;
    } tone_req_t;

endpackage

//--- source/lock_pkg.sv
package lock_pkg;

    typedef logic [15:0] keys_t;       // one-hot keypad lines
    typedef logic [3:0]  digit_t;      // bcd, 4'hF is blank
    typedef logic [11:0] display_t;    // three digits, newest in low nibble
    typedef logic [2:0]  tries_t;      // failed attempts
    typedef logic [2:0]  digit_cnt_t;  // digits held in the buffer

    localparam int unsigned NUM_DIGITS = 3;

    localparam digit_t   DIGIT_BLANK = 4'hF;
    localparam display_t DISP_BLANK  = {3{DIGIT_BLANK}};
    localparam display_t DISP_OPEN   = 12'hA55;  // "ASS"
    localparam display_t DISP_LOCKED = 12'h000;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_ENTER,
        KEY_CLEAR,
        KEY_RESET
    } key_kind_e;

    // one decoded key press
    typedef struct packed {
        key_kind_e kind;
        digit_t    digit;  // only valid for KEY_DIGIT
    } key_evt_t;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKOUT
    } lock_state_e;

endpackage
